// ==== vlog.f ====
hw/gnn_pkg.sv
hw/feature_accumulator.sv
hw/edge_pe.sv
hw/bus_arbiter.sv
hw/aggregation_cluster.sv
bench/clock_gen.sv
bench/cluster_checker.sv
bench/tb_aggregation_cluster.sv

// ==== Bender.yml ====
package:
  name: aggregation_cluster

sources:
  - files:
      - hw/gnn_pkg.sv
      - hw/feature_accumulator.sv
      - hw/edge_pe.sv
      - hw/bus_arbiter.sv
      - hw/aggregation_cluster.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/cluster_checker.sv
      - bench/tb_aggregation_cluster.sv

// ==== bench/tb_aggregation_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_aggregation_cluster;
    import gnn_pkg::*;

    localparam logic [31:0] SEED = 32'h452afb50;
    localparam int NUM_NODES      = 1 << NODE_W;
    localparam int DIRECTED_TASKS = 8;
    localparam int RANDOM_TASKS   = 60;
    localparam int MAX_LATENCY    = 4;
    localparam int RESET_CYCLES   = 5;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + 20 + 200 * (DIRECTED_TASKS + RANDOM_TASKS);

    logic              clk;
    logic              reset;
    logic [NUM_PE-1:0] task_valid;
    node_id_t          task_node [NUM_PE];
    logic [NUM_PE-1:0] idle;
    logic [NUM_PE-1:0] done;
    feature_t          result [NUM_PE];
    node_id_t          result_node [NUM_PE];
    logic              mem_req;
    req_kind_t         mem_kind;
    node_id_t          mem_node;
    logic              mem_rsp_valid;
    feature_t          mem_rsp_data;
    degree_t           mem_rsp_count;

    // graph image
    degree_t  degree [NUM_NODES];
    id_list_t nbr_list [NUM_NODES];
    feature_t node_feat [NUM_NODES];

    logic [31:0]       stim_rng;
    logic [31:0]       mem_rng;
    logic [NUM_PE-1:0] outstanding;  // task given, done not yet seen
    node_id_t          exp_node [NUM_PE];
    logic              started;
    int                exp_mem_reqs;
    int                mem_reqs;
    int                tasks_done;
    logic              rsp_pending;
    int                rsp_wait;
    feature_t          rsp_data_q;
    degree_t           rsp_count_q;

    clock_gen i_clock_gen (.clk(clk), .reset(reset));

    aggregation_cluster i_aggregation_cluster (
        .clk           (clk),
        .reset         (reset),
        .task_valid    (task_valid),
        .task_node     (task_node),
        .idle          (idle),
        .done          (done),
        .result        (result),
        .result_node   (result_node),
        .mem_req       (mem_req),
        .mem_kind      (mem_kind),
        .mem_node      (mem_node),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_count (mem_rsp_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    function automatic logic [31:0] next_mem_rand();
        mem_rng = xorshift32(mem_rng);
        return mem_rng;
    endfunction

    // lane-wise wrap-around sum over the neighbor list
    function automatic feature_t expected_sum(input node_id_t node);
        lane_t    lanes [LANES];
        node_id_t nbr;
        feature_t out;
        for (int l = 0; l < LANES; l++) lanes[l] = '0;
        for (int k = 0; k < int'(degree[node]); k++) begin
            nbr = nbr_list[node][k*NODE_W +: NODE_W];
            for (int l = 0; l < LANES; l++) begin
                lanes[l] = lanes[l] + node_feat[nbr][l*LANE_W +: LANE_W];
            end
        end
        for (int l = 0; l < LANES; l++) out[l*LANE_W +: LANE_W] = lanes[l];
        return out;
    endfunction

    task automatic stop_failed();
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_error(input string why);
        $display("ERROR t=%0t %s", $time, why);
        stop_failed();
    endtask

    task automatic check_feature(input feature_t got, input feature_t exp, input string name);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_node(input node_id_t got, input node_id_t exp, input string name);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
            stop_failed();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
            stop_failed();
        end
    endtask

    task automatic build_graph();
        for (int n = 0; n < NUM_NODES; n++) begin
            degree[n]    = degree_t'(next_rand() % (MAX_DEGREE + 1));
            nbr_list[n]  = id_list_t'({next_rand(), next_rand()});  // unused slots stay junk
            node_feat[n] = {next_rand(), next_rand()};
        end
        degree[0] = '0;
        degree[1] = degree_t'(MAX_DEGREE);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        task_valid = '0;
    endtask

    task automatic start_task(input int p, input node_id_t node);
        task_valid[p] = 1'b1;
        task_node[p]  = node;
        exp_node[p]   = node;
        outstanding[p] = 1'b1;
        started       = 1'b1;
        exp_mem_reqs += 1 + int'(degree[node]);
    endtask

    task automatic wait_all_done();
        while (outstanding != '0) next_cycle();
    endtask

    task automatic run_single(input int p, input node_id_t node);
        next_cycle();
        start_task(p, node);
        wait_all_done();
    endtask

    task automatic random_run();
        int issued;
        issued = 0;
        while (issued < RANDOM_TASKS) begin
            next_cycle();
            for (int p = 0; p < NUM_PE; p++) begin
                if (issued < RANDOM_TASKS && idle[p] && !outstanding[p]
                        && next_rand() % 2 == 0) begin
                    start_task(p, node_id_t'(next_rand()));
                    issued++;
                end
            end
        end
    endtask

    // memory model, one response per request after 1..MAX_LATENCY cycles
    always @(negedge clk) begin
        mem_rsp_valid = 1'b0;
        if (rsp_pending) begin
            rsp_wait--;
            if (rsp_wait == 0) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = rsp_data_q;
                mem_rsp_count = rsp_count_q;
                rsp_pending   = 1'b0;
            end
        end
        if (!reset && mem_req) begin
            if (rsp_pending) report_error("memory request while a response is still pending");
            mem_reqs++;
            rsp_pending = 1'b1;
            rsp_wait    = 1 + int'(next_mem_rand() % MAX_LATENCY);
            if (mem_kind == REQ_LIST) begin
                rsp_data_q  = feature_t'(nbr_list[mem_node]);
                rsp_count_q = degree[mem_node];
            end else begin
                rsp_data_q  = node_feat[mem_node];
                rsp_count_q = degree_t'(next_mem_rand());  // junk, ignored by the PE
            end
        end
    end

    // compare, a little after the falling edge
    always @(negedge clk) begin
        #1;
        if (!reset) begin
            if (i_aggregation_cluster.i_bus_arbiter.i_cluster_checker.assert_errors != 0)
                report_error("a bound assertion on the arbiter failed");
            if (!started) check_bit(mem_req, 1'b0, "mem_req");
            for (int p = 0; p < NUM_PE; p++) begin
                if (done[p]) begin
                    if (!outstanding[p])
                        report_error($sformatf("PE %0d raised done with no task in flight", p));
                    check_bit(idle[p], 1'b1, $sformatf("idle[%0d]", p));
                    check_node(result_node[p], exp_node[p], $sformatf("result_node[%0d]", p));
                    check_feature(result[p], expected_sum(exp_node[p]),
                                  $sformatf("result[%0d]", p));
                    outstanding[p] = 1'b0;
                    tasks_done++;
                end else if (outstanding[p] && !task_valid[p]) begin
                    check_bit(idle[p], 1'b0, $sformatf("idle[%0d]", p));
                end else begin
                    check_bit(idle[p], 1'b1, $sformatf("idle[%0d]", p));
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_error($sformatf("watchdog expired after %0d cycles, %0d tasks done",
                               WATCHDOG_CYCLES, tasks_done));
    end

    initial begin
        stim_rng      = SEED;
        mem_rng       = ~SEED;
        task_valid    = '0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        mem_rsp_count = '0;
        outstanding   = '0;
        started       = 1'b0;
        exp_mem_reqs  = 0;
        mem_reqs      = 0;
        tasks_done    = 0;
        rsp_pending   = 1'b0;
        rsp_wait      = 0;
        for (int p = 0; p < NUM_PE; p++) begin
            task_node[p] = '0;
            exp_node[p]  = '0;
        end
        build_graph();
        @(negedge reset);
        repeat (10) next_cycle();  // quiet after reset
        run_single(0, 0);          // degree 0
        run_single(0, 1);          // degree 9
        run_single(0, 2);
        run_single(0, 3);
        run_single(1, 1);
        run_single(1, 4);
        next_cycle();
        start_task(0, 5);
        start_task(1, 1);
        wait_all_done();
        random_run();
        wait_all_done();
        repeat (8) next_cycle();  // room for a stray second done
        if (mem_reqs != exp_mem_reqs) begin
            $display("MISMATCH t=%0t mem_req count got %0d expected %0d",
                     $time, mem_reqs, exp_mem_reqs);
            stop_failed();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== bench/cluster_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cluster_checker (
    input logic                       clk,
    input logic                       reset,
    input logic [gnn_pkg::NUM_PE-1:0] pe_req,
    input logic [gnn_pkg::NUM_PE-1:0] pe_gnt,
    input logic                       mem_req,
    input logic                       mem_rsp_valid
);

    int   assert_errors = 0;  // read by the testbench
    logic in_flight;          // request out, response not back yet

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 1'b0;
        end else if (mem_req) begin
            in_flight <= 1'b1;
        end else if (mem_rsp_valid) begin
            in_flight <= 1'b0;
        end
    end

    a_gnt_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(pe_gnt))
        else begin
            assert_errors++;
            $error("more than one PE granted in the same cycle");
        end

    a_no_req_busy: assert property (@(posedge clk) disable iff (reset) !(mem_req && in_flight))
        else begin
            assert_errors++;
            $error("memory request issued before the previous response came back");
        end

    // request and grant go out together
    a_req_with_gnt: assert property (@(posedge clk) disable iff (reset)
            mem_req == (|(pe_gnt & pe_req)))
        else begin
            assert_errors++;
            $error("memory request and grant to a requesting PE out of step");
        end

    // granted PE lets go of its request
    a_gnt_drops_req: assert property (@(posedge clk) disable iff (reset)
            (|pe_gnt) |=> ((pe_req & $past(pe_gnt)) == '0))
        else begin
            assert_errors++;
            $error("PE still requesting in the cycle after its grant");
        end

endmodule

bind bus_arbiter cluster_checker i_cluster_checker (
    .clk           (clk),
    .reset         (reset),
    .pe_req        (pe_req),
    .pe_gnt        (pe_gnt),
    .mem_req       (mem_req),
    .mem_rsp_valid (mem_rsp_valid)
);

`default_nettype wire

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // released on the falling edge after 5 rising edges
    initial begin
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== hw/aggregation_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

module aggregation_cluster (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [gnn_pkg::NUM_PE-1:0]  task_valid,
    input  gnn_pkg::node_id_t           task_node [gnn_pkg::NUM_PE],
    output logic [gnn_pkg::NUM_PE-1:0]  idle,
    output logic [gnn_pkg::NUM_PE-1:0]  done,
    output gnn_pkg::feature_t           result [gnn_pkg::NUM_PE],
    output gnn_pkg::node_id_t           result_node [gnn_pkg::NUM_PE],
    output logic                        mem_req,
    output gnn_pkg::req_kind_t          mem_kind,
    output gnn_pkg::node_id_t           mem_node,
    input  logic                        mem_rsp_valid,
    input  gnn_pkg::feature_t           mem_rsp_data,
    input  gnn_pkg::degree_t            mem_rsp_count
);
    import gnn_pkg::*;

    logic [NUM_PE-1:0] pe_req;
    logic [NUM_PE-1:0] pe_gnt;
    logic [NUM_PE-1:0] pe_rsp_valid;
    req_kind_t         pe_kind [NUM_PE];
    node_id_t          pe_node [NUM_PE];

    // data and count go to every PE, only the strobe is steered
    for (genvar p = 0; p < NUM_PE; p++) begin : g_pe
        edge_pe i_edge_pe (
            .clk          (clk),
            .reset        (reset),
            .task_valid   (task_valid[p]),
            .task_node    (task_node[p]),
            .idle         (idle[p]),
            .pe_req       (pe_req[p]),
            .pe_kind      (pe_kind[p]),
            .pe_node      (pe_node[p]),
            .pe_gnt       (pe_gnt[p]),
            .pe_rsp_valid (pe_rsp_valid[p]),
            .rsp_data     (mem_rsp_data),
            .rsp_count    (mem_rsp_count),
            .done         (done[p]),
            .result       (result[p]),
            .result_node  (result_node[p])
        );
    end

    bus_arbiter i_bus_arbiter (
        .clk           (clk),
        .reset         (reset),
        .pe_req        (pe_req),
        .pe_kind       (pe_kind),
        .pe_node       (pe_node),
        .pe_gnt        (pe_gnt),
        .pe_rsp_valid  (pe_rsp_valid),
        .mem_req       (mem_req),
        .mem_kind      (mem_kind),
        .mem_node      (mem_node),
        .mem_rsp_valid (mem_rsp_valid)
    );

endmodule

`default_nettype wire

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [gnn_pkg::NUM_PE-1:0]  pe_req,
    input  gnn_pkg::req_kind_t          pe_kind [gnn_pkg::NUM_PE],
    input  gnn_pkg::node_id_t           pe_node [gnn_pkg::NUM_PE],
    output logic [gnn_pkg::NUM_PE-1:0]  pe_gnt,
    output logic [gnn_pkg::NUM_PE-1:0]  pe_rsp_valid,
    output logic                        mem_req,
    output gnn_pkg::req_kind_t          mem_kind,
    output gnn_pkg::node_id_t           mem_node,
    input  logic                        mem_rsp_valid
);
    import gnn_pkg::*;

    logic    busy;    // one request in flight
    logic    found;
    pe_sel_t rr_ptr;  // highest priority PE this round
    pe_sel_t owner;
    pe_sel_t pick;

    always_comb begin
        int cand;
        found = 1'b0;
        pick  = rr_ptr;
        for (int i = 0; i < NUM_PE; i++) begin
            cand = (int'(rr_ptr) + i) % NUM_PE;
            if (!found && pe_req[cand]) begin
                found = 1'b1;
                pick  = pe_sel_t'(cand);
            end
        end
    end

    assign mem_req  = !busy && found;
    assign mem_kind = pe_kind[pick];
    assign mem_node = pe_node[pick];

    always_comb begin
        pe_gnt       = '0;
        pe_rsp_valid = '0;
        if (mem_req) pe_gnt[pick] = 1'b1;
        if (mem_rsp_valid) pe_rsp_valid[owner] = 1'b1;  // strobe back to winner
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy   <= 1'b0;
            rr_ptr <= '0;
        end else if (mem_req) begin
            busy   <= 1'b1;
            rr_ptr <= pe_sel_t'((int'(pick) + 1) % NUM_PE);
        end else if (mem_rsp_valid) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req) owner <= pick;
    end

endmodule

`default_nettype wire

// ==== hw/edge_pe.sv ====
`timescale 1ns/1ps
`default_nettype none

module edge_pe (
    input  logic               clk,
    input  logic               reset,
    input  logic               task_valid,
    input  gnn_pkg::node_id_t  task_node,
    output logic               idle,
    output logic               pe_req,
    output gnn_pkg::req_kind_t pe_kind,
    output gnn_pkg::node_id_t  pe_node,
    input  logic               pe_gnt,
    input  logic               pe_rsp_valid,
    input  gnn_pkg::feature_t  rsp_data,
    input  gnn_pkg::degree_t   rsp_count,
    output logic               done,
    output gnn_pkg::feature_t  result,
    output gnn_pkg::node_id_t  result_node
);
    import gnn_pkg::*;

    pe_state_t state;
    pe_state_t state_next;
    node_id_t  target;
    node_id_t  nbr_ids [MAX_DEGREE];
    degree_t   nbr_count;
    degree_t   ptr;          // next neighbor to fetch
    id_list_t  list_word;
    logic      accept;
    logic      list_arrive;
    logic      feat_arrive;

    assign accept      = task_valid && idle;
    assign list_word   = rsp_data[MAX_DEGREE*NODE_W-1:0];
    assign list_arrive = (state == ST_WAIT_LIST) && pe_rsp_valid;
    assign feat_arrive = (state == ST_WAIT_FEAT) && pe_rsp_valid;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE, ST_FINISH: begin
                // a new task may land in the done cycle
                if (accept) begin
                    state_next = ST_REQ_LIST;
                end else begin
                    state_next = ST_IDLE;
                end
            end
            ST_REQ_LIST: if (pe_gnt) state_next = ST_WAIT_LIST;
            ST_WAIT_LIST: begin
                if (pe_rsp_valid) begin
                    state_next = (rsp_count == '0) ? ST_FINISH : ST_REQ_FEAT;
                end
            end
            ST_REQ_FEAT: if (pe_gnt) state_next = ST_WAIT_FEAT;
            ST_WAIT_FEAT: begin
                if (pe_rsp_valid) begin
                    if (degree_t'(ptr + 1'b1) == nbr_count) begin
                        state_next = ST_FINISH;
                    end else begin
                        state_next = ST_REQ_FEAT;
                    end
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            target <= task_node;
        end
        if (list_arrive) begin
            nbr_count <= rsp_count;
            ptr       <= '0;
            for (int i = 0; i < MAX_DEGREE; i++) begin
                nbr_ids[i] <= list_word[i*NODE_W +: NODE_W];
            end
        end else if (feat_arrive) begin
            ptr <= ptr + 1'b1;
        end
    end

    feature_accumulator i_feature_accumulator (
        .clk     (clk),
        .reset   (reset),
        .clear   (accept),
        .add     (feat_arrive),
        .operand (rsp_data),
        .sum     (result)
    );

    assign idle        = (state == ST_IDLE) || (state == ST_FINISH);
    assign pe_req      = (state == ST_REQ_LIST) || (state == ST_REQ_FEAT);
    assign pe_kind     = (state == ST_REQ_LIST) ? REQ_LIST : REQ_FEATURE;
    assign pe_node     = (state == ST_REQ_LIST) ? target : nbr_ids[ptr];
    assign done        = (state == ST_FINISH);
    assign result_node = target;

endmodule

`default_nettype wire

// ==== hw/feature_accumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module feature_accumulator (
    input  logic              clk,
    input  logic              reset,
    input  logic              clear,
    input  logic              add,
    input  gnn_pkg::feature_t operand,
    output gnn_pkg::feature_t sum
);
    import gnn_pkg::*;

    lane_t lanes [LANES];

    // lane sums wrap at 2^LANE_W
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            for (int i = 0; i < LANES; i++) begin
                lanes[i] <= '0;
            end
        end else if (add) begin
            for (int i = 0; i < LANES; i++) begin
                lanes[i] <= lanes[i] + operand[i*LANE_W +: LANE_W];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            sum[i*LANE_W +: LANE_W] = lanes[i];
        end
    end

endmodule

`default_nettype wire

// ==== hw/gnn_pkg.sv ====
`default_nettype none

package gnn_pkg;

    localparam int NUM_PE     = 2;
    localparam int NODE_W     = 7;
    localparam int MAX_DEGREE = 9;
    localparam int LANES      = 4;
    localparam int LANE_W     = 16;

    typedef logic [NODE_W-1:0]            node_id_t;
    typedef logic [3:0]                   degree_t;   // 0 .. MAX_DEGREE
    typedef logic [LANE_W-1:0]            lane_t;
    typedef logic [LANES*LANE_W-1:0]      feature_t;  // lane 0 in low bits
    typedef logic [MAX_DEGREE*NODE_W-1:0] id_list_t;  // id 0 in low bits
    typedef logic [0:0]                   pe_sel_t;
    typedef logic                         req_kind_t;

    localparam req_kind_t REQ_LIST    = 1'b0;
    localparam req_kind_t REQ_FEATURE = 1'b1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ_LIST,
        ST_WAIT_LIST,
        ST_REQ_FEAT,
        ST_WAIT_FEAT,
        ST_FINISH
    } pe_state_t;

endpackage

`default_nettype wire
